/* design/soc_bus_pkg.sv */
// Shared widths, window constants and ID-width helpers, referenced by scoped name from the RTL
package soc_bus_pkg;

  localparam int unsigned aw = 32;  // Address bits
  localparam int unsigned dw = 32;  // Data bits

  // Crossbar target indices
  localparam int unsigned tgt_l2     = 0;
  localparam int unsigned tgt_periph = 1;
  localparam int unsigned tgt_ext    = 2;

  // Peripheral window is fixed
  localparam logic [aw-1:0] periph_base  = 32'h1A10_0000;
  localparam logic [aw-1:0] periph_bytes = 32'h0000_1000;  // 4 KiB

  // Programmable map, values after reset
  localparam logic [aw-1:0] l2_base_rst  = 32'h1C00_0000;
  localparam logic [aw-1:0] l2_size_rst  = 32'h0000_4000;  // 16 KiB
  localparam logic [aw-1:0] ext_base_rst = l2_base_rst + l2_size_rst;  // First byte past L2

  function automatic int unsigned n_targets();
    return 3;  // L2, peripherals, external
  endfunction

  // Target-side ID carries the initiator index above the initiator's own ID
  function automatic int unsigned out_id_w(input int unsigned n_init, input int unsigned iw);
    int unsigned idx_w;
    idx_w = (n_init > 1) ? $clog2(n_init) : 1;
    return iw + idx_w;
  endfunction

endpackage

/* design/addr_decoder.sv */
// Window compare for one request address, used by the crossbar once per initiator
`timescale 1ns/100ps

module addr_decoder (
  input  logic [soc_bus_pkg::aw-1:0]                  addr,
  input  logic [soc_bus_pkg::aw-1:0]                  l2_base,
  input  logic [soc_bus_pkg::aw-1:0]                  l2_size,
  input  logic [soc_bus_pkg::aw-1:0]                  ext_base,
  output logic [$clog2(soc_bus_pkg::n_targets())-1:0] tgt_idx,
  output logic                                        miss
);

  localparam int unsigned TW = $clog2(soc_bus_pkg::n_targets());

  logic [soc_bus_pkg::aw-1:0] periph_off;
  logic [soc_bus_pkg::aw-1:0] l2_off;

  // Offsets instead of end addresses, no overflow at the top of memory
  assign periph_off = addr - soc_bus_pkg::periph_base;
  assign l2_off     = addr - l2_base;

  always_comb begin
    tgt_idx = TW'(soc_bus_pkg::tgt_l2);
    miss    = 1'b0;
    if (addr >= soc_bus_pkg::periph_base && periph_off < soc_bus_pkg::periph_bytes) begin
      tgt_idx = TW'(soc_bus_pkg::tgt_periph);  // Fixed window wins
    end else if (addr >= l2_base && l2_off < l2_size) begin
      tgt_idx = TW'(soc_bus_pkg::tgt_l2);
    end else if (addr >= ext_base) begin
      tgt_idx = TW'(soc_bus_pkg::tgt_ext);     // Up to the top of the space
    end else begin
      miss = 1'b1;
    end
  end

endmodule

/* design/rr_arbiter.sv */
// Round-robin grant among initiators for one crossbar target, held until accepted
`timescale 1ns/100ps

module rr_arbiter #(
  parameter int unsigned N_INIT = 2
) (
  input  logic              clk_i,
  input  logic              rst,
  input  logic [N_INIT-1:0] req,
  input  logic              accept,
  output logic [N_INIT-1:0] grant
);

  localparam int unsigned PW = (N_INIT > 1) ? $clog2(N_INIT) : 1;

  logic [PW-1:0]     last_q;    // Last accepted winner
  logic              hold_q;
  logic [N_INIT-1:0] held_q;
  logic [N_INIT-1:0] rr_grant;
  logic [PW-1:0]     win_idx;

  // Search starts just after the last winner
  always_comb begin
    int idx;
    rr_grant = '0;
    for (int k = 1; k <= N_INIT; k++) begin
      idx = (int'(last_q) + k) % N_INIT;
      if (rr_grant == '0 && req[idx]) rr_grant[idx] = 1'b1;
    end
  end

  assign grant = (hold_q && |(held_q & req)) ? held_q : rr_grant;

  always_comb begin
    win_idx = '0;
    for (int i = 0; i < N_INIT; i++) begin
      if (grant[i]) win_idx = PW'(i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      last_q <= PW'(N_INIT - 1);  // Initiator 0 first
      hold_q <= 1'b0;
      held_q <= '0;
    end else if (accept) begin
      last_q <= win_idx;
      hold_q <= 1'b0;
    end else if (|grant) begin
      hold_q <= 1'b1;             // Keep the winner until its transfer
      held_q <= grant;
    end
  end

  a_grant_onehot: assert property (@(posedge clk_i) disable iff (rst) $onehot0(grant));

endmodule

/* design/addr_map_regs.sv */
// Programmable address map in the peripheral window, steers the crossbar decoders
`timescale 1ns/100ps

module addr_map_regs #(
  parameter int unsigned IW = 5
) (
  input  logic                       clk_i,
  input  logic                       rst,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  logic [soc_bus_pkg::aw-1:0] req_addr,
  input  logic                       req_we,
  input  logic [soc_bus_pkg::dw-1:0] req_wdata,
  input  logic [IW-1:0]              req_id,
  output logic                       rsp_valid,
  input  logic                       rsp_ready,
  output logic [soc_bus_pkg::dw-1:0] rsp_rdata,
  output logic                       rsp_err,
  output logic [IW-1:0]              rsp_id,
  output logic [soc_bus_pkg::aw-1:0] l2_base,
  output logic [soc_bus_pkg::aw-1:0] l2_size,
  output logic [soc_bus_pkg::aw-1:0] ext_base
);

  logic [soc_bus_pkg::aw-1:0] off;
  logic [soc_bus_pkg::dw-1:0] rd_word;
  logic                       hit;
  logic                       accept;
  logic                       live_q;

  assign off       = req_addr - soc_bus_pkg::periph_base;
  assign req_ready = live_q && (!rsp_valid || rsp_ready);  // Slot empty or draining
  assign accept    = req_valid && req_ready;

  always_comb begin
    rd_word = '0;
    hit     = 1'b1;
    case (off)
      32'h0:   rd_word = l2_base;
      32'h4:   rd_word = l2_size;
      32'h8:   rd_word = ext_base;
      default: hit = 1'b0;  // Unused offset
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      live_q    <= 1'b0;
      rsp_valid <= 1'b0;
      l2_base   <= soc_bus_pkg::l2_base_rst;
      l2_size   <= soc_bus_pkg::l2_size_rst;
      ext_base  <= soc_bus_pkg::ext_base_rst;
    end else begin
      live_q <= 1'b1;
      if (accept) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
      if (accept && req_we) begin
        case (off)
          32'h0:   l2_base  <= req_wdata;
          32'h4:   l2_size  <= req_wdata;
          32'h8:   ext_base <= req_wdata;
          default: ;
        endcase
      end
    end
  end

  // Response payload, ID echoed unchanged
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id    <= req_id;
      rsp_err   <= !hit;
      rsp_rdata <= (req_we || !hit) ? '0 : rd_word;
    end
  end

endmodule

/* design/l2_mem.sv */
// On-chip L2 SRAM target, word addressed, response one cycle after acceptance
`timescale 1ns/100ps

module l2_mem #(
  parameter int unsigned IW       = 5,
  parameter int unsigned L2_WORDS = 4096
) (
  input  logic                       clk_i,
  input  logic                       rst,
  input  logic                       req_valid,
  output logic                       req_ready,
  input  logic [soc_bus_pkg::aw-1:0] req_addr,
  input  logic                       req_we,
  input  logic [soc_bus_pkg::dw-1:0] req_wdata,
  input  logic [IW-1:0]              req_id,
  output logic                       rsp_valid,
  input  logic                       rsp_ready,
  output logic [soc_bus_pkg::dw-1:0] rsp_rdata,
  output logic                       rsp_err,
  output logic [IW-1:0]              rsp_id,
  input  logic [soc_bus_pkg::aw-1:0] l2_base
);

  localparam int unsigned AXW = $clog2(L2_WORDS);
  localparam logic [soc_bus_pkg::aw-1:0] WORDS = L2_WORDS;

  logic [soc_bus_pkg::dw-1:0] mem [L2_WORDS];
  logic [soc_bus_pkg::aw-1:0] offset;
  logic [AXW-1:0]             idx;
  logic                       in_range;
  logic                       accept;
  logic                       live_q;

  assign offset    = req_addr - l2_base;
  assign idx       = offset[AXW+1:2];
  assign in_range  = (offset >> 2) < WORDS;  // Window may be set larger than the array
  assign req_ready = live_q && (!rsp_valid || rsp_ready);
  assign accept    = req_valid && req_ready;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      live_q    <= 1'b0;
      rsp_valid <= 1'b0;
    end else begin
      live_q <= 1'b1;
      if (accept) begin
        rsp_valid <= 1'b1;
      end else if (rsp_ready) begin
        rsp_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rsp_id    <= req_id;
      rsp_err   <= !in_range;
      rsp_rdata <= '0;  // Writes answer with zero
      if (in_range) begin
        if (req_we) begin
          mem[idx] <= req_wdata;
        end else begin
          rsp_rdata <= mem[idx];
        end
      end
    end
  end

endmodule

/* design/bus_xbar.sv */
// Request crossbar: decode, per-target arbitration and request register, ID widening, response return
`timescale 1ns/100ps

module bus_xbar #(
  parameter  int unsigned N_INIT = 2,
  parameter  int unsigned IW     = 4,
  localparam int unsigned NT     = soc_bus_pkg::n_targets(),
  localparam int unsigned OW     = soc_bus_pkg::out_id_w(N_INIT, IW)
) (
  input  logic                                    clk_i,
  input  logic                                    rst,
  input  logic [N_INIT-1:0]                       init_req_valid,
  output logic [N_INIT-1:0]                       init_req_ready,
  input  logic [N_INIT-1:0][soc_bus_pkg::aw-1:0]  init_req_addr,
  input  logic [N_INIT-1:0]                       init_req_we,
  input  logic [N_INIT-1:0][soc_bus_pkg::dw-1:0]  init_req_wdata,
  input  logic [N_INIT-1:0][IW-1:0]               init_req_id,
  output logic [N_INIT-1:0]                       init_rsp_valid,
  input  logic [N_INIT-1:0]                       init_rsp_ready,
  output logic [N_INIT-1:0][soc_bus_pkg::dw-1:0]  init_rsp_rdata,
  output logic [N_INIT-1:0]                       init_rsp_err,
  output logic [N_INIT-1:0][IW-1:0]               init_rsp_id,
  output logic [NT-1:0]                           tgt_req_valid,
  input  logic [NT-1:0]                           tgt_req_ready,
  output logic [NT-1:0][soc_bus_pkg::aw-1:0]      tgt_req_addr,
  output logic [NT-1:0]                           tgt_req_we,
  output logic [NT-1:0][soc_bus_pkg::dw-1:0]      tgt_req_wdata,
  output logic [NT-1:0][OW-1:0]                   tgt_req_id,
  input  logic [NT-1:0]                           tgt_rsp_valid,
  output logic [NT-1:0]                           tgt_rsp_ready,
  input  logic [NT-1:0][soc_bus_pkg::dw-1:0]      tgt_rsp_rdata,
  input  logic [NT-1:0]                           tgt_rsp_err,
  input  logic [NT-1:0][OW-1:0]                   tgt_rsp_id,
  input  logic [soc_bus_pkg::aw-1:0]              l2_base,
  input  logic [soc_bus_pkg::aw-1:0]              l2_size,
  input  logic [soc_bus_pkg::aw-1:0]              ext_base
);

  localparam int unsigned TW = $clog2(NT);
  localparam int unsigned XW = OW - IW;  // Initiator index bits

  logic [N_INIT-1:0][TW-1:0] dec_idx;
  logic [N_INIT-1:0]         dec_miss;
  logic [N_INIT-1:0]         busy_q;       // One request in flight per initiator
  logic [N_INIT-1:0]         err_valid_q;  // Decode-miss response pending
  logic [N_INIT-1:0][IW-1:0] err_id_q;
  logic [NT-1:0][N_INIT-1:0] arb_req;
  logic [NT-1:0][N_INIT-1:0] arb_grant;
  logic [NT-1:0]             slot_free;
  logic [NT-1:0]             load;
  logic [NT-1:0][XW-1:0]     rsp_src;
  logic                      live_q;

  for (genvar i = 0; i < N_INIT; i++) begin : gen_init
    addr_decoder i_dec (
      .addr     (init_req_addr[i]),
      .l2_base  (l2_base),
      .l2_size  (l2_size),
      .ext_base (ext_base),
      .tgt_idx  (dec_idx[i]),
      .miss     (dec_miss[i])
    );

    a_req_stable: assert property (@(posedge clk_i) disable iff (rst)
      init_req_valid[i] && !init_req_ready[i] |=> init_req_valid[i] &&
      $stable(init_req_addr[i]) && $stable(init_req_we[i]) &&
      $stable(init_req_wdata[i]) && $stable(init_req_id[i]));
  end

  always_comb begin
    for (int t = 0; t < NT; t++) begin
      for (int i = 0; i < N_INIT; i++) begin
        arb_req[t][i] = live_q && init_req_valid[i] && !busy_q[i] && !dec_miss[i] &&
                        dec_idx[i] == TW'(t);
      end
    end
  end

  for (genvar t = 0; t < NT; t++) begin : gen_tgt
    logic [XW-1:0]              win;
    logic                       v_q;
    logic [soc_bus_pkg::aw-1:0] addr_q;
    logic                       we_q;
    logic [soc_bus_pkg::dw-1:0] wdata_q;
    logic [OW-1:0]              id_q;

    assign slot_free[t] = !v_q || tgt_req_ready[t];
    assign load[t]      = slot_free[t] && |arb_grant[t];

    rr_arbiter #(.N_INIT(N_INIT)) i_arb (
      .clk_i  (clk_i),
      .rst    (rst),
      .req    (arb_req[t]),
      .accept (load[t]),
      .grant  (arb_grant[t])
    );

    always_comb begin
      win = '0;
      for (int i = 0; i < N_INIT; i++) begin
        if (arb_grant[t][i]) win = XW'(i);
      end
    end

    always_ff @(posedge clk_i) begin
      if (rst) begin
        v_q <= 1'b0;
      end else if (slot_free[t]) begin
        v_q <= |arb_grant[t];
      end
    end

    always_ff @(posedge clk_i) begin
      if (load[t]) begin
        addr_q  <= init_req_addr[win];
        we_q    <= init_req_we[win];
        wdata_q <= init_req_wdata[win];
        id_q    <= {win, init_req_id[win]};  // Widen by initiator index
      end
    end

    assign tgt_req_valid[t] = v_q;
    assign tgt_req_addr[t]  = addr_q;
    assign tgt_req_we[t]    = we_q;
    assign tgt_req_wdata[t] = wdata_q;
    assign tgt_req_id[t]    = id_q;

    // Return path stalls with the owning initiator
    assign rsp_src[t]       = tgt_rsp_id[t][OW-1:IW];
    assign tgt_rsp_ready[t] = tgt_rsp_valid[t] && (32'(rsp_src[t]) < N_INIT) &&
                              init_rsp_ready[rsp_src[t]];

    a_rsp_src: assert property (@(posedge clk_i) disable iff (rst)
      tgt_rsp_valid[t] |-> 32'(rsp_src[t]) < N_INIT);
  end

  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      if (dec_miss[i]) begin
        init_req_ready[i] = live_q && !busy_q[i];  // Answered locally
      end else begin
        init_req_ready[i] = arb_grant[dec_idx[i]][i] && slot_free[dec_idx[i]];
      end
    end
  end

  // At most one source per initiator at a time
  always_comb begin
    for (int i = 0; i < N_INIT; i++) begin
      init_rsp_valid[i] = err_valid_q[i];
      init_rsp_rdata[i] = '0;
      init_rsp_err[i]   = err_valid_q[i];
      init_rsp_id[i]    = err_id_q[i];
      for (int t = 0; t < NT; t++) begin
        if (tgt_rsp_valid[t] && rsp_src[t] == XW'(i)) begin
          init_rsp_valid[i] = 1'b1;
          init_rsp_rdata[i] = tgt_rsp_rdata[t];
          init_rsp_err[i]   = tgt_rsp_err[t];
          init_rsp_id[i]    = tgt_rsp_id[t][IW-1:0];  // Strip the index
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      live_q      <= 1'b0;
      busy_q      <= '0;
      err_valid_q <= '0;
    end else begin
      live_q <= 1'b1;
      for (int i = 0; i < N_INIT; i++) begin
        if (init_req_valid[i] && init_req_ready[i]) begin
          busy_q[i]      <= 1'b1;
          err_valid_q[i] <= dec_miss[i];
        end else if (init_rsp_valid[i] && init_rsp_ready[i]) begin
          busy_q[i]      <= 1'b0;
          err_valid_q[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < N_INIT; i++) begin
      if (init_req_valid[i] && init_req_ready[i] && dec_miss[i]) err_id_q[i] <= init_req_id[i];
    end
  end

endmodule

/* design/soc_bus.sv */
// SoC bus top level: crossbar, map registers and L2 memory, with the external target port exposed
`timescale 1ns/100ps

module soc_bus #(
  parameter  int unsigned N_INIT   = 2,
  parameter  int unsigned IW       = 4,
  parameter  int unsigned L2_WORDS = 4096,
  localparam int unsigned OW       = soc_bus_pkg::out_id_w(N_INIT, IW)
) (
  input  logic                                   clk_i,
  input  logic                                   rst,
  input  logic [N_INIT-1:0]                      init_req_valid,
  output logic [N_INIT-1:0]                      init_req_ready,
  input  logic [N_INIT-1:0][soc_bus_pkg::aw-1:0] init_req_addr,
  input  logic [N_INIT-1:0]                      init_req_we,
  input  logic [N_INIT-1:0][soc_bus_pkg::dw-1:0] init_req_wdata,
  input  logic [N_INIT-1:0][IW-1:0]              init_req_id,
  output logic [N_INIT-1:0]                      init_rsp_valid,
  input  logic [N_INIT-1:0]                      init_rsp_ready,
  output logic [N_INIT-1:0][soc_bus_pkg::dw-1:0] init_rsp_rdata,
  output logic [N_INIT-1:0]                      init_rsp_err,
  output logic [N_INIT-1:0][IW-1:0]              init_rsp_id,
  output logic                                   ext_req_valid,
  input  logic                                   ext_req_ready,
  output logic [soc_bus_pkg::aw-1:0]             ext_req_addr,
  output logic                                   ext_req_we,
  output logic [soc_bus_pkg::dw-1:0]             ext_req_wdata,
  output logic [OW-1:0]                          ext_req_id,
  input  logic                                   ext_rsp_valid,
  output logic                                   ext_rsp_ready,
  input  logic [soc_bus_pkg::dw-1:0]             ext_rsp_rdata,
  input  logic                                   ext_rsp_err,
  input  logic [OW-1:0]                          ext_rsp_id
);

  // L2 target channel
  logic                       l2_req_valid;
  logic                       l2_req_ready;
  logic [soc_bus_pkg::aw-1:0] l2_req_addr;
  logic                       l2_req_we;
  logic [soc_bus_pkg::dw-1:0] l2_req_wdata;
  logic [OW-1:0]              l2_req_id;
  logic                       l2_rsp_valid;
  logic                       l2_rsp_ready;
  logic [soc_bus_pkg::dw-1:0] l2_rsp_rdata;
  logic                       l2_rsp_err;
  logic [OW-1:0]              l2_rsp_id;

  // Peripheral window channel
  logic                       map_req_valid;
  logic                       map_req_ready;
  logic [soc_bus_pkg::aw-1:0] map_req_addr;
  logic                       map_req_we;
  logic [soc_bus_pkg::dw-1:0] map_req_wdata;
  logic [OW-1:0]              map_req_id;
  logic                       map_rsp_valid;
  logic                       map_rsp_ready;
  logic [soc_bus_pkg::dw-1:0] map_rsp_rdata;
  logic                       map_rsp_err;
  logic [OW-1:0]              map_rsp_id;

  logic [soc_bus_pkg::aw-1:0] l2_base;
  logic [soc_bus_pkg::aw-1:0] l2_size;
  logic [soc_bus_pkg::aw-1:0] ext_base;

  // Target arrays ordered ext, periph, L2 from the top index down
  bus_xbar #(
    .N_INIT (N_INIT),
    .IW     (IW)
  ) i_xbar (
    .clk_i          (clk_i),
    .rst            (rst),
    .init_req_valid (init_req_valid),
    .init_req_ready (init_req_ready),
    .init_req_addr  (init_req_addr),
    .init_req_we    (init_req_we),
    .init_req_wdata (init_req_wdata),
    .init_req_id    (init_req_id),
    .init_rsp_valid (init_rsp_valid),
    .init_rsp_ready (init_rsp_ready),
    .init_rsp_rdata (init_rsp_rdata),
    .init_rsp_err   (init_rsp_err),
    .init_rsp_id    (init_rsp_id),
    .tgt_req_valid  ({ext_req_valid, map_req_valid, l2_req_valid}),
    .tgt_req_ready  ({ext_req_ready, map_req_ready, l2_req_ready}),
    .tgt_req_addr   ({ext_req_addr, map_req_addr, l2_req_addr}),
    .tgt_req_we     ({ext_req_we, map_req_we, l2_req_we}),
    .tgt_req_wdata  ({ext_req_wdata, map_req_wdata, l2_req_wdata}),
    .tgt_req_id     ({ext_req_id, map_req_id, l2_req_id}),
    .tgt_rsp_valid  ({ext_rsp_valid, map_rsp_valid, l2_rsp_valid}),
    .tgt_rsp_ready  ({ext_rsp_ready, map_rsp_ready, l2_rsp_ready}),
    .tgt_rsp_rdata  ({ext_rsp_rdata, map_rsp_rdata, l2_rsp_rdata}),
    .tgt_rsp_err    ({ext_rsp_err, map_rsp_err, l2_rsp_err}),
    .tgt_rsp_id     ({ext_rsp_id, map_rsp_id, l2_rsp_id}),
    .l2_base        (l2_base),
    .l2_size        (l2_size),
    .ext_base       (ext_base)
  );

  addr_map_regs #(
    .IW (OW)
  ) i_map (
    .clk_i     (clk_i),
    .rst       (rst),
    .req_valid (map_req_valid),
    .req_ready (map_req_ready),
    .req_addr  (map_req_addr),
    .req_we    (map_req_we),
    .req_wdata (map_req_wdata),
    .req_id    (map_req_id),
    .rsp_valid (map_rsp_valid),
    .rsp_ready (map_rsp_ready),
    .rsp_rdata (map_rsp_rdata),
    .rsp_err   (map_rsp_err),
    .rsp_id    (map_rsp_id),
    .l2_base   (l2_base),
    .l2_size   (l2_size),
    .ext_base  (ext_base)
  );

  l2_mem #(
    .IW       (OW),
    .L2_WORDS (L2_WORDS)
  ) i_l2 (
    .clk_i     (clk_i),
    .rst       (rst),
    .req_valid (l2_req_valid),
    .req_ready (l2_req_ready),
    .req_addr  (l2_req_addr),
    .req_we    (l2_req_we),
    .req_wdata (l2_req_wdata),
    .req_id    (l2_req_id),
    .rsp_valid (l2_rsp_valid),
    .rsp_ready (l2_rsp_ready),
    .rsp_rdata (l2_rsp_rdata),
    .rsp_err   (l2_rsp_err),
    .rsp_id    (l2_rsp_id),
    .l2_base   (l2_base)
  );

endmodule

/* dv/soc_bus_tb.sv */
// Table-driven testbench for soc_bus, two initiators in parallel and a model of the external port
`timescale 1ns/100ps

module soc_bus_tb;

  localparam int unsigned N_INIT   = 2;
  localparam int unsigned IW       = 4;
  localparam int unsigned L2_WORDS = 4096;
  localparam int unsigned OW       = soc_bus_pkg::out_id_w(N_INIT, IW);

  typedef struct packed {
    logic [1:0]                 phase;  // Rows of one phase run together
    logic                       init;
    logic [soc_bus_pkg::aw-1:0] addr;
    logic                       we;
    logic [soc_bus_pkg::dw-1:0] wdata;
    logic [IW-1:0]              id;
    logic [soc_bus_pkg::dw-1:0] rdata;  // Expected response
    logic                       err;
  } row_t;

  logic                                   clk_i = 1'b0;
  logic                                   rst;
  logic [N_INIT-1:0]                      init_req_valid;
  logic [N_INIT-1:0]                      init_req_ready;
  logic [N_INIT-1:0][soc_bus_pkg::aw-1:0] init_req_addr;
  logic [N_INIT-1:0]                      init_req_we;
  logic [N_INIT-1:0][soc_bus_pkg::dw-1:0] init_req_wdata;
  logic [N_INIT-1:0][IW-1:0]              init_req_id;
  logic [N_INIT-1:0]                      init_rsp_valid;
  logic [N_INIT-1:0]                      init_rsp_ready;
  logic [N_INIT-1:0][soc_bus_pkg::dw-1:0] init_rsp_rdata;
  logic [N_INIT-1:0]                      init_rsp_err;
  logic [N_INIT-1:0][IW-1:0]              init_rsp_id;
  logic                                   ext_req_valid;
  logic                                   ext_req_ready;
  logic [soc_bus_pkg::aw-1:0]             ext_req_addr;
  logic                                   ext_req_we;
  logic [soc_bus_pkg::dw-1:0]             ext_req_wdata;
  logic [OW-1:0]                          ext_req_id;
  logic                                   ext_rsp_valid;
  logic                                   ext_rsp_ready;
  logic [soc_bus_pkg::dw-1:0]             ext_rsp_rdata;
  logic                                   ext_rsp_err;
  logic [OW-1:0]                          ext_rsp_id;

  row_t                       rows[$];
  logic [soc_bus_pkg::aw-1:0] cur_addr [N_INIT];  // Request in flight per initiator
  logic [IW-1:0]              cur_id [N_INIT];
  int                         nrsp [N_INIT];      // Response handshakes seen on the port
  int                         errors = 0;
  int                         cycles = 0;
  int                         limit = 0;
  int                         seed = 90895;

  always #4 clk_i = ~clk_i;

  soc_bus #(
    .N_INIT   (N_INIT),
    .IW       (IW),
    .L2_WORDS (L2_WORDS)
  ) dut_i (
    .clk_i          (clk_i),
    .rst            (rst),
    .init_req_valid (init_req_valid),
    .init_req_ready (init_req_ready),
    .init_req_addr  (init_req_addr),
    .init_req_we    (init_req_we),
    .init_req_wdata (init_req_wdata),
    .init_req_id    (init_req_id),
    .init_rsp_valid (init_rsp_valid),
    .init_rsp_ready (init_rsp_ready),
    .init_rsp_rdata (init_rsp_rdata),
    .init_rsp_err   (init_rsp_err),
    .init_rsp_id    (init_rsp_id),
    .ext_req_valid  (ext_req_valid),
    .ext_req_ready  (ext_req_ready),
    .ext_req_addr   (ext_req_addr),
    .ext_req_we     (ext_req_we),
    .ext_req_wdata  (ext_req_wdata),
    .ext_req_id     (ext_req_id),
    .ext_rsp_valid  (ext_rsp_valid),
    .ext_rsp_ready  (ext_rsp_ready),
    .ext_rsp_rdata  (ext_rsp_rdata),
    .ext_rsp_err    (ext_rsp_err),
    .ext_rsp_id     (ext_rsp_id)
  );

  task automatic check_data(input logic [soc_bus_pkg::dw-1:0] got,
                            input logic [soc_bus_pkg::dw-1:0] exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_err(input logic got, input logic exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s got %b expected %b", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic check_id(input logic [IW-1:0] got, input logic [IW-1:0] exp, input string msg);
    if (got !== exp) begin
      $display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  task automatic add_row(input int phase, input int init, input logic [31:0] addr, input int we,
                         input logic [31:0] wdata, input int id, input logic [31:0] rdata,
                         input int err);
    row_t r;
    r.phase = 2'(phase);
    r.init  = 1'(init);
    r.addr  = addr;
    r.we    = 1'(we);
    r.wdata = wdata;
    r.id    = IW'(id);
    r.rdata = rdata;
    r.err   = 1'(err);
    rows.push_back(r);
  endtask

  // Phase, initiator, address, we, wdata, id, expected rdata, expected err
  task automatic fill_table();
    add_row(0, 0, 32'h1C00_0010, 1, 32'h1111_0000, 3, 32'h0000_0000, 0);  // L2 at reset map
    add_row(0, 1, 32'h1C00_0020, 1, 32'h2222_0000, 5, 32'h0000_0000, 0);
    add_row(0, 0, 32'h1C00_0010, 0, 32'h0000_0000, 3, 32'h1111_0000, 0);
    add_row(0, 1, 32'h1C00_0020, 0, 32'h0000_0000, 5, 32'h2222_0000, 0);
    add_row(0, 0, 32'h1C00_0100, 1, 32'h3333_0001, 1, 32'h0000_0000, 0);  // Contending streams
    add_row(0, 1, 32'h1C00_0200, 1, 32'h4444_0002, 2, 32'h0000_0000, 0);
    add_row(0, 0, 32'h1C00_0104, 1, 32'h3333_0003, 1, 32'h0000_0000, 0);
    add_row(0, 1, 32'h1C00_0204, 1, 32'h4444_0004, 2, 32'h0000_0000, 0);
    add_row(0, 0, 32'h1C00_0100, 0, 32'h0000_0000, 4, 32'h3333_0001, 0);
    add_row(0, 1, 32'h1C00_0200, 0, 32'h0000_0000, 6, 32'h4444_0002, 0);
    add_row(0, 0, 32'h1C00_0104, 0, 32'h0000_0000, 4, 32'h3333_0003, 0);
    add_row(0, 1, 32'h1C00_0204, 0, 32'h0000_0000, 6, 32'h4444_0004, 0);
    add_row(0, 0, 32'h1000_0000, 0, 32'h0000_0000, 8, 32'h0000_0000, 1);  // Unmapped
    add_row(0, 1, 32'h0000_0100, 1, 32'h0000_ABCD, 9, 32'h0000_0000, 1);
    add_row(0, 1, 32'h1A10_000C, 0, 32'h0000_0000, 10, 32'h0000_0000, 1); // Unused map offset
    add_row(0, 1, 32'h1A10_0000, 0, 32'h0000_0000, 11, 32'h1C00_0000, 0);
    add_row(0, 1, 32'h1A10_0004, 0, 32'h0000_0000, 12, 32'h0000_4000, 0);
    add_row(0, 0, 32'h2000_0000, 1, 32'hDEAD_BEEF, 7, 32'h0000_0000, 0);  // External
    add_row(0, 0, 32'h2000_0000, 0, 32'h0000_0000, 7, 32'hDEAD_BEEF, 0);
    add_row(0, 1, 32'h2000_0004, 1, 32'hCAFE_0001, 13, 32'h0000_0000, 0);
    add_row(0, 1, 32'h2000_0004, 0, 32'h0000_0000, 13, 32'hCAFE_0001, 0);
    add_row(0, 0, 32'h1C00_4008, 1, 32'h5555_AAAA, 14, 32'h0000_0000, 0); // Just above ext_base
    add_row(0, 0, 32'h1C00_4008, 0, 32'h0000_0000, 14, 32'h5555_AAAA, 0);
    add_row(1, 0, 32'h1A10_0000, 1, 32'h1D00_0000, 2, 32'h0000_0000, 0);  // Move L2
    add_row(1, 0, 32'h1A10_0008, 1, 32'h1D00_4000, 2, 32'h0000_0000, 0);
    add_row(1, 0, 32'h1A10_0000, 0, 32'h0000_0000, 2, 32'h1D00_0000, 0);
    add_row(1, 0, 32'h1A10_0008, 0, 32'h0000_0000, 2, 32'h1D00_4000, 0);
    add_row(1, 0, 32'h1D00_0010, 0, 32'h0000_0000, 3, 32'h1111_0000, 0);
    add_row(1, 0, 32'h1C00_0010, 0, 32'h0000_0000, 3, 32'h0000_0000, 1);  // Old L2 now a hole
    add_row(2, 1, 32'h1D00_0020, 0, 32'h0000_0000, 5, 32'h2222_0000, 0);
    add_row(2, 1, 32'h1D00_4010, 1, 32'h0BAD_F00D, 15, 32'h0000_0000, 0);
    add_row(2, 1, 32'h1D00_4010, 0, 32'h0000_0000, 15, 32'h0BAD_F00D, 0);
    add_row(2, 0, 32'h1D00_0104, 0, 32'h0000_0000, 1, 32'h3333_0003, 0);
    add_row(2, 0, 32'h1A10_0004, 0, 32'h0000_0000, 0, 32'h0000_4000, 0);
  endtask

  // One request and its response, called at posedge plus 1 ns
  task automatic do_row(input int i, input int r, inout int lseed);
    logic [soc_bus_pkg::dw-1:0] cap_rdata;
    logic                       cap_err;
    logic [IW-1:0]              cap_id;
    bit                         seen;
    bit                         done;
    row_t                       row;
    row  = rows[r];
    seen = 1'b0;
    done = 1'b0;
    cur_addr[i]       = row.addr;
    cur_id[i]         = row.id;
    init_req_valid[i] = 1'b1;
    init_req_addr[i]  = row.addr;
    init_req_we[i]    = row.we;
    init_req_wdata[i] = row.wdata;
    init_req_id[i]    = row.id;
    @(negedge clk_i);
    while (!init_req_ready[i]) @(negedge clk_i);
    @(posedge clk_i);
    #1;
    init_req_valid[i] = 1'b0;
    while (!done) begin
      init_rsp_ready[i] = ({$random(lseed)} % 32'd3) != 32'd0;  // Random stalls
      @(negedge clk_i);
      if (init_rsp_valid[i]) begin
        if (seen) begin
          check_data(init_rsp_rdata[i], cap_rdata, $sformatf("row %0d held rdata", r));
          check_err(init_rsp_err[i], cap_err, $sformatf("row %0d held err", r));
          check_id(init_rsp_id[i], cap_id, $sformatf("row %0d held id", r));
        end
        cap_rdata = init_rsp_rdata[i];
        cap_err   = init_rsp_err[i];
        cap_id    = init_rsp_id[i];
        seen      = 1'b1;
        done      = init_rsp_ready[i];
      end
      @(posedge clk_i);
      #1;
    end
    init_rsp_ready[i] = 1'b0;
    check_data(cap_rdata, row.rdata, $sformatf("row %0d rdata", r));
    check_err(cap_err, row.err, $sformatf("row %0d err", r));
    check_id(cap_id, row.id, $sformatf("row %0d id", r));
    @(negedge clk_i);
    if (init_rsp_valid[i]) begin
      $display("Initiator %0d still sees a response after taking row %0d", i, r);
      errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  task automatic run_init(input int i, input int p);
    int lseed;
    lseed = seed + 16 * p + i + 1;
    for (int r = 0; r < rows.size(); r++) begin
      if (int'(rows[r].init) == i && int'(rows[r].phase) == p) do_row(i, r, lseed);
    end
  endtask

  // Counted where valid and ready meet, one count per transfer
  always @(negedge clk_i) begin
    for (int i = 0; i < N_INIT; i++) begin
      if (init_rsp_valid[i] === 1'b1 && init_rsp_ready[i] === 1'b1) nrsp[i] = nrsp[i] + 1;
    end
  end

  // External target, one request at a time with random latency
  initial begin : ext_model
    logic [soc_bus_pkg::dw-1:0] ext_mem [16];
    logic [soc_bus_pkg::dw-1:0] rdata;
    logic [OW-1:0]              id;
    int                         delay;
    int                         src;
    ext_req_ready = 1'b0;
    ext_rsp_valid = 1'b0;
    ext_rsp_rdata = '0;
    ext_rsp_err   = 1'b0;
    ext_rsp_id    = '0;
    @(negedge rst);
    forever begin
      delay = {$random(seed)} % 32'd4;
      repeat (delay) begin
        @(posedge clk_i);
        #1;
      end
      ext_req_ready = 1'b1;
      @(negedge clk_i);
      while (!ext_req_valid) @(negedge clk_i);
      src = int'(ext_req_id[OW-1:IW]);  // Initiator index above the original ID
      check_id(ext_req_id[IW-1:0], cur_id[src], "external request id");
      check_data(ext_req_addr, cur_addr[src], "external request address");
      id    = ext_req_id;
      rdata = '0;
      if (ext_req_we) ext_mem[ext_req_addr[5:2]] = ext_req_wdata;
      else rdata = ext_mem[ext_req_addr[5:2]];
      @(posedge clk_i);
      #1;
      ext_req_ready = 1'b0;
      delay = {$random(seed)} % 32'd5;
      repeat (delay) begin
        @(posedge clk_i);
        #1;
      end
      ext_rsp_valid = 1'b1;
      ext_rsp_rdata = rdata;
      ext_rsp_err   = 1'b0;
      ext_rsp_id    = id;
      @(negedge clk_i);
      while (!ext_rsp_ready) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      ext_rsp_valid = 1'b0;
    end
  end

  always @(posedge clk_i) begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      $display("Run timed out after %0d cycles", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  initial begin
    int n_exp;
    rst            = 1'b1;
    init_req_valid = '0;
    init_req_addr  = '0;
    init_req_we    = '0;
    init_req_wdata = '0;
    init_req_id    = '0;
    init_rsp_ready = '0;
    nrsp[0]        = 0;
    nrsp[1]        = 0;
    fill_table();
    limit = 40 * rows.size();
    repeat (2) @(posedge clk_i);
    #1;
    rst = 1'b0;
    for (int p = 0; p < 3; p++) begin
      fork
        run_init(0, p);
        run_init(1, p);
      join
    end
    for (int i = 0; i < N_INIT; i++) begin
      n_exp = 0;
      foreach (rows[r]) if (int'(rows[r].init) == i) n_exp++;
      if (nrsp[i] != n_exp) begin
        $display("Initiator %0d finished %0d of %0d transfers", i, nrsp[i], n_exp);
        errors++;
      end
    end
    $display("Responses %0d and %0d, errors %0d", nrsp[0], nrsp[1], errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* src.f */
design/soc_bus_pkg.sv
design/addr_decoder.sv
design/rr_arbiter.sv
design/addr_map_regs.sv
design/l2_mem.sv
design/bus_xbar.sv
design/soc_bus.sv
dv/soc_bus_tb.sv

/* run.sh */
#!/bin/sh
# Builds the SoC bus testbench with Verilator, runs it and checks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module soc_bus_tb -o soc_bus_sim

out=$(./obj_dir/soc_bus_sim)
echo "$out"

if echo "$out" | grep -qx "Done: no errors"; then
  exit 0
else
  exit 1
fi
